/* all.f */
+incdir+source
source/mipsDecodePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/operandIssue.sv
source/decodeStage.sv
tb/decodeStageTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module decodeStageTb \
    -Mdir obj_dir -o decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/decodeStageSim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "=== PASS ==="; then
    exit 0
else
    exit 1
fi

/* source/decodeStage.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module decodeStage (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      instrValid,
    input  logic [`DATA_WIDTH-1:0]    instr,
    input  logic [`DATA_WIDTH-1:0]    pc,
    input  logic                      writeEnable,
    input  logic [`REG_IDX_WIDTH-1:0] writeReg,
    input  logic [`DATA_WIDTH-1:0]    writeData,
    output logic                      outValid,
    output logic [`DATA_WIDTH-1:0]    instrOut,
    output logic [`DATA_WIDTH-1:0]    pcOut,
    output logic [`DATA_WIDTH-1:0]    operandA,
    output logic [`DATA_WIDTH-1:0]    operandB,
    output logic [`REG_IDX_WIDTH-1:0] writeRegOut,
    output logic                      regWriteOut,
    output logic                      memReadOut,
    output logic                      memWriteOut,
    output logic [`DATA_WIDTH-1:0]    memWriteData,
    output mipsDecodePkg::aluOp_t     aluOpOut,
    output logic [`REG_IDX_WIDTH-1:0] shiftAmount,
    output logic [`DATA_WIDTH-1:0]    altPc,
    output logic                      requestAltPc,
    output logic                      sys
);
    import mipsDecodePkg::*;

    // Decoder controls
    logic   link;
    logic   regDst;
    logic   jump;
    logic   jumpReg;
    logic   branch;
    logic   branchNotEqual;
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    logic   signExtend;
    logic   syscall;
    aluOp_t aluOp;

    // Source register values
    logic [`DATA_WIDTH-1:0] rsValue;
    logic [`DATA_WIDTH-1:0] rtValue;

    // ********************
    // Decode and read side by side
    // ********************

    instrDecoder decoder (
        .instr          (instr),
        .link           (link),
        .regDst         (regDst),
        .jump           (jump),
        .jumpReg        (jumpReg),
        .branch         (branch),
        .branchNotEqual (branchNotEqual),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .regWrite       (regWrite),
        .signExtend     (signExtend),
        .syscall        (syscall),
        .aluOp          (aluOp)
    );

    // rs and rt are always read, unused values are ignored downstream
    regFile registers (
        .CLK         (CLK),
        .RESET       (RESET),
        .readRegA    (instr[`RS_RANGE]),
        .readRegB    (instr[`RT_RANGE]),
        .writeEnable (writeEnable),
        .writeReg    (writeReg),
        .writeData   (writeData),
        .readDataA   (rsValue),
        .readDataB   (rtValue)
    );

    // ********************
    // Issue to execute
    // ********************

    operandIssue issue (
        .CLK            (CLK),
        .RESET          (RESET),
        .instrValid     (instrValid),
        .instr          (instr),
        .pc             (pc),
        .link           (link),
        .regDst         (regDst),
        .jump           (jump),
        .jumpReg        (jumpReg),
        .branch         (branch),
        .branchNotEqual (branchNotEqual),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .regWrite       (regWrite),
        .signExtend     (signExtend),
        .syscall        (syscall),
        .aluOp          (aluOp),
        .rsValue        (rsValue),
        .rtValue        (rtValue),
        .outValid       (outValid),
        .instrOut       (instrOut),
        .pcOut          (pcOut),
        .operandA       (operandA),
        .operandB       (operandB),
        .writeRegOut    (writeRegOut),
        .regWriteOut    (regWriteOut),
        .memReadOut     (memReadOut),
        .memWriteOut    (memWriteOut),
        .memWriteData   (memWriteData),
        .aluOpOut       (aluOpOut),
        .shiftAmount    (shiftAmount),
        .altPc          (altPc),
        .requestAltPc   (requestAltPc),
        .sys            (sys)
    );

endmodule

/* source/instrDecoder.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module instrDecoder (
    input  logic [`DATA_WIDTH-1:0] instr,
    output logic                   link,
    output logic                   regDst,
    output logic                   jump,
    output logic                   jumpReg,
    output logic                   branch,
    output logic                   branchNotEqual,
    output logic                   memRead,
    output logic                   memWrite,
    output logic                   regWrite,
    output logic                   signExtend,
    output logic                   syscall,
    output mipsDecodePkg::aluOp_t  aluOp
);
    import mipsDecodePkg::*;

    opcode_t opcode;
    funct_t  funct;

    // Raw fields viewed as enums, unknown values fall to default
    assign opcode = opcode_t'(instr[`OPCODE_RANGE]);
    assign funct  = funct_t'(instr[`FUNCT_RANGE]);

    always_comb begin
        // Everything low unless a known encoding says otherwise
        link           = 1'b0;
        regDst         = 1'b0;
        jump           = 1'b0;
        jumpReg        = 1'b0;
        branch         = 1'b0;
        branchNotEqual = 1'b0;
        memRead        = 1'b0;
        memWrite       = 1'b0;
        regWrite       = 1'b0;
        signExtend     = 1'b0;
        syscall        = 1'b0;
        aluOp          = ALU_NOP;

        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    F_SLL:  aluOp = ALU_SLL;
                    F_SRL:  aluOp = ALU_SRL;
                    F_SRA:  aluOp = ALU_SRA;
                    F_ADDU: aluOp = ALU_ADD;
                    F_SUBU: aluOp = ALU_SUB;
                    F_AND:  aluOp = ALU_AND;
                    F_OR:   aluOp = ALU_OR;
                    F_XOR:  aluOp = ALU_XOR;
                    F_NOR:  aluOp = ALU_NOR;
                    F_SLT:  aluOp = ALU_SLT;
                    F_JR: begin
                        jump    = 1'b1;
                        jumpReg = 1'b1;
                    end
                    // Return address goes through the ALU as 0 + (pc + 8)
                    F_JALR: begin
                        jump    = 1'b1;
                        jumpReg = 1'b1;
                        link    = 1'b1;
                        aluOp   = ALU_ADD;
                    end
                    F_SYSCALL: syscall = 1'b1;
                    default: ;
                endcase
                // Any known funct selects rd
                regDst   = (aluOp != ALU_NOP) || jump || syscall;
                // JR and SYSCALL leave the register file alone
                regWrite = (aluOp != ALU_NOP);
            end
            OP_J: jump = 1'b1;
            OP_JAL: begin
                jump     = 1'b1;
                link     = 1'b1;
                regWrite = 1'b1;
                aluOp    = ALU_ADD;
            end
            // Branch compare happens in decode, SUB is informational
            OP_BEQ: begin
                branch     = 1'b1;
                signExtend = 1'b1;
                aluOp      = ALU_SUB;
            end
            OP_BNE: begin
                branch         = 1'b1;
                branchNotEqual = 1'b1;
                signExtend     = 1'b1;
                aluOp          = ALU_SUB;
            end
            OP_ADDIU: begin
                signExtend = 1'b1;
                regWrite   = 1'b1;
                aluOp      = ALU_ADD;
            end
            OP_SLTI: begin
                signExtend = 1'b1;
                regWrite   = 1'b1;
                aluOp      = ALU_SLT;
            end
            // Logical immediates are zero extended
            OP_ANDI: begin
                regWrite = 1'b1;
                aluOp    = ALU_AND;
            end
            OP_ORI: begin
                regWrite = 1'b1;
                aluOp    = ALU_OR;
            end
            OP_XORI: begin
                regWrite = 1'b1;
                aluOp    = ALU_XOR;
            end
            OP_LUI: begin
                regWrite = 1'b1;
                aluOp    = ALU_LUI;
            end
            // Address = rs + signed offset
            OP_LW: begin
                memRead    = 1'b1;
                regWrite   = 1'b1;
                signExtend = 1'b1;
                aluOp      = ALU_ADD;
            end
            OP_SW: begin
                memWrite   = 1'b1;
                signExtend = 1'b1;
                aluOp      = ALU_ADD;
            end
            default: ;
        endcase
    end

endmodule

/* source/mipsDecodePkg.sv */
package mipsDecodePkg;

    // ********************
    // Major opcodes
    // ********************

    // Only the supported subset, anything else decodes as a NOP
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // ********************
    // SPECIAL function codes
    // ********************

    typedef enum logic [5:0] {
        // Shifts by shamt
        F_SLL     = 6'h00,
        F_SRL     = 6'h02,
        F_SRA     = 6'h03,
        // Register jumps
        F_JR      = 6'h08,
        F_JALR    = 6'h09,
        F_SYSCALL = 6'h0c,
        // Register ALU ops
        F_ADDU    = 6'h21,
        F_SUBU    = 6'h23,
        F_AND     = 6'h24,
        F_OR      = 6'h25,
        F_XOR     = 6'h26,
        F_NOR     = 6'h27,
        F_SLT     = 6'h2a
    } funct_t;

    // ********************
    // ALU operations to execute
    // ********************

    typedef enum logic [3:0] {
        ALU_NOP = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_NOR = 4'd6,
        ALU_SLT = 4'd7,
        ALU_SLL = 4'd8,
        ALU_SRL = 4'd9,
        ALU_SRA = 4'd10,
        // Immediate into upper half
        ALU_LUI = 4'd11
    } aluOp_t;

endpackage

/* source/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// ********************
// Machine word
// ********************

// Register, PC and instruction width
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 32
`define REG_IDX_WIDTH 5

// Return address register for JAL
`define LINK_REG 31

// ********************
// Instruction fields
// ********************

// Common to all formats
`define OPCODE_RANGE 31:26
`define RS_RANGE 25:21
`define RT_RANGE 20:16

// R-type only
`define RD_RANGE 15:11
`define SHAMT_RANGE 10:6
`define FUNCT_RANGE 5:0

// I-type immediate
`define IMM_RANGE 15:0
`define IMM_WIDTH 16

// J-type target, joined with the upper PC region
`define TARGET_RANGE 25:0
`define PC_REGION_RANGE 31:28

`endif

/* source/operandIssue.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module operandIssue (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic                      instrValid,
    input  logic [`DATA_WIDTH-1:0]    instr,
    input  logic [`DATA_WIDTH-1:0]    pc,
    input  logic                      link,
    input  logic                      regDst,
    input  logic                      jump,
    input  logic                      jumpReg,
    input  logic                      branch,
    input  logic                      branchNotEqual,
    input  logic                      memRead,
    input  logic                      memWrite,
    input  logic                      regWrite,
    input  logic                      signExtend,
    input  logic                      syscall,
    input  mipsDecodePkg::aluOp_t     aluOp,
    input  logic [`DATA_WIDTH-1:0]    rsValue,
    input  logic [`DATA_WIDTH-1:0]    rtValue,
    output logic                      outValid,
    output logic [`DATA_WIDTH-1:0]    instrOut,
    output logic [`DATA_WIDTH-1:0]    pcOut,
    output logic [`DATA_WIDTH-1:0]    operandA,
    output logic [`DATA_WIDTH-1:0]    operandB,
    output logic [`REG_IDX_WIDTH-1:0] writeRegOut,
    output logic                      regWriteOut,
    output logic                      memReadOut,
    output logic                      memWriteOut,
    output logic [`DATA_WIDTH-1:0]    memWriteData,
    output mipsDecodePkg::aluOp_t     aluOpOut,
    output logic [`REG_IDX_WIDTH-1:0] shiftAmount,
    output logic [`DATA_WIDTH-1:0]    altPc,
    output logic                      requestAltPc,
    output logic                      sys
);
    import mipsDecodePkg::*;

    localparam logic [`REG_IDX_WIDTH-1:0] linkReg = `LINK_REG;

    logic [`DATA_WIDTH-1:0]    pcPlus4;
    logic [`DATA_WIDTH-1:0]    pcPlus8;
    logic [`IMM_WIDTH-1:0]     imm;
    logic [`DATA_WIDTH-1:0]    signImm;
    logic [`DATA_WIDTH-1:0]    extImm;
    logic [`DATA_WIDTH-1:0]    opA;
    logic [`DATA_WIDTH-1:0]    opB;
    logic [`REG_IDX_WIDTH-1:0] destReg;
    logic [`DATA_WIDTH-1:0]    targetPc;
    logic                      takeAlt;

    // ********************
    // Operands
    // ********************

    assign pcPlus4 = pc + 4;
    // Return address skips the delay slot
    assign pcPlus8 = pc + 8;
    assign imm     = instr[`IMM_RANGE];
    assign signImm = {{(`DATA_WIDTH - `IMM_WIDTH){imm[`IMM_WIDTH-1]}}, imm};
    assign extImm  = signExtend ? signImm : {{(`DATA_WIDTH - `IMM_WIDTH){1'b0}}, imm};

    // Link forms compute 0 + return address
    assign opA = link ? '0 : rsValue;
    assign opB = link ? pcPlus8 : ((branch || regDst) ? rtValue : extImm);

    // rd for R-type, r31 for JAL, rt otherwise
    assign destReg = regDst ? instr[`RD_RANGE] : (link ? linkReg : instr[`RT_RANGE]);

    // ********************
    // Branch and jump
    // ********************

    always_comb begin
        if (jumpReg) begin
            targetPc = rsValue;
        end else if (jump) begin
            // Stays inside the current 256 MB region
            targetPc = {pcPlus4[`PC_REGION_RANGE], instr[`TARGET_RANGE], 2'b00};
        end else if (branch) begin
            targetPc = pcPlus4 + {signImm[`DATA_WIDTH-3:0], 2'b00};
        end else begin
            targetPc = '0;
        end
    end

    // Taken when unconditional, or when the compare matches the sense
    assign takeAlt = jump || (branch && ((rsValue == rtValue) != branchNotEqual));

    // ********************
    // Output register
    // ********************

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            outValid     <= 1'b0;
            instrOut     <= '0;
            pcOut        <= '0;
            operandA     <= '0;
            operandB     <= '0;
            writeRegOut  <= '0;
            regWriteOut  <= 1'b0;
            memReadOut   <= 1'b0;
            memWriteOut  <= 1'b0;
            memWriteData <= '0;
            aluOpOut     <= ALU_NOP;
            shiftAmount  <= '0;
            altPc        <= '0;
            requestAltPc <= 1'b0;
            sys          <= 1'b0;
        end else if (instrValid) begin
            outValid     <= 1'b1;
            instrOut     <= instr;
            pcOut        <= pc;
            operandA     <= opA;
            operandB     <= opB;
            writeRegOut  <= destReg;
            // Writes to r0 are dropped here
            regWriteOut  <= regWrite && (destReg != '0);
            memReadOut   <= memRead;
            memWriteOut  <= memWrite;
            memWriteData <= rtValue;
            aluOpOut     <= aluOp;
            shiftAmount  <= instr[`SHAMT_RANGE];
            altPc        <= targetPc;
            requestAltPc <= takeAlt;
            sys          <= syscall;
        end else begin
            // Bubble, execute sees all zeros
            outValid     <= 1'b0;
            instrOut     <= '0;
            pcOut        <= '0;
            operandA     <= '0;
            operandB     <= '0;
            writeRegOut  <= '0;
            regWriteOut  <= 1'b0;
            memReadOut   <= 1'b0;
            memWriteOut  <= 1'b0;
            memWriteData <= '0;
            aluOpOut     <= ALU_NOP;
            shiftAmount  <= '0;
            altPc        <= '0;
            requestAltPc <= 1'b0;
            sys          <= 1'b0;
        end
    end

endmodule

/* source/regFile.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module regFile (
    input  logic                      CLK,
    input  logic                      RESET,
    input  logic [`REG_IDX_WIDTH-1:0] readRegA,
    input  logic [`REG_IDX_WIDTH-1:0] readRegB,
    input  logic                      writeEnable,
    input  logic [`REG_IDX_WIDTH-1:0] writeReg,
    input  logic [`DATA_WIDTH-1:0]    writeData,
    output logic [`DATA_WIDTH-1:0]    readDataA,
    output logic [`DATA_WIDTH-1:0]    readDataB
);

    // ********************
    // Storage
    // ********************

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Writes land on the edge, so a same-cycle read sees the old value
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeReg != '0)) begin
            // Register 0 is never written
            regs[writeReg] <= writeData;
        end
    end

    // ********************
    // Read ports
    // ********************

    // Port A, normally rs
    always_comb begin
        if (readRegA == '0) begin
            readDataA = '0;
        end else begin
            readDataA = regs[readRegA];
        end
    end

    // Port B, normally rt
    always_comb begin
        if (readRegB == '0) begin
            readDataB = '0;
        end else begin
            readDataB = regs[readRegB];
        end
    end

endmodule

/* tb/decodeStageTb.sv */
`timescale 1ns/1ps
`include "mips_defines.svh"

module decodeStageTb;
    import mipsDecodePkg::*;

    // ********************
    // Run length
    // ********************

    localparam int resetCycles = 10;
    localparam int idleCycles  = 4;
    localparam int initWrites  = `REG_COUNT - 1;
    localparam int numBursts   = 100;
    localparam int burstLen    = 4;
    localparam int gapLen      = 2;
    localparam int tailCycles  = 3;
    localparam int totalCycles = resetCycles + idleCycles + initWrites
                               + numBursts * (burstLen + gapLen) + tailCycles + 1;
    localparam int cycleLimit  = totalCycles * 3 / 2;

    // Supported encodings to pick from
    localparam logic [5:0] functList [13] = '{F_SLL, F_SRL, F_SRA, F_JR, F_JALR, F_SYSCALL,
                                              F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT};
    localparam logic [5:0] opList [12] = '{OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDIU, OP_SLTI,
                                           OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW};

    typedef struct packed {
        logic                      valid;
        logic [`DATA_WIDTH-1:0]    instr;
        logic [`DATA_WIDTH-1:0]    pc;
        logic [`DATA_WIDTH-1:0]    opA;
        logic [`DATA_WIDTH-1:0]    opB;
        logic [`REG_IDX_WIDTH-1:0] writeReg;
        logic                      regWrite;
        logic                      memRead;
        logic                      memWrite;
        logic [`DATA_WIDTH-1:0]    memData;
        logic [3:0]                aluOp;
        logic [`REG_IDX_WIDTH-1:0] shamt;
        logic [`DATA_WIDTH-1:0]    altPc;
        logic                      reqAlt;
        logic                      sys;
    } decodeResult_t;

    logic CLK;
    logic RESET;
    logic instrValid;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] pc;
    logic writeEnable;
    logic [`REG_IDX_WIDTH-1:0] writeReg;
    logic [`DATA_WIDTH-1:0] writeData;
    logic outValid;
    logic [`DATA_WIDTH-1:0] instrOut;
    logic [`DATA_WIDTH-1:0] pcOut;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`REG_IDX_WIDTH-1:0] writeRegOut;
    logic regWriteOut;
    logic memReadOut;
    logic memWriteOut;
    logic [`DATA_WIDTH-1:0] memWriteData;
    aluOp_t aluOpOut;
    logic [`REG_IDX_WIDTH-1:0] shiftAmount;
    logic [`DATA_WIDTH-1:0] altPc;
    logic requestAltPc;
    logic sys;

    // Shadow register file and expectation pipeline
    logic [`DATA_WIDTH-1:0] shadow [`REG_COUNT];
    decodeResult_t expectedNext = '0;
    decodeResult_t expectedNow = '0;
    logic [31:0] lfsrState;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    decodeStage DUT (.*);

    // ********************
    // Random source
    // ********************

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One step per bit taken
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
        return value;
    endfunction

    function automatic logic [31:0] randomInstr();
        logic [31:0] word;
        int kind;
        word = randomBits(32);
        kind = int'(randomBits(5)) % 26;
        if (kind < 13) begin
            word[`OPCODE_RANGE] = OP_SPECIAL;
            word[`FUNCT_RANGE]  = functList[kind];
        end else if (kind < 25) begin
            word[`OPCODE_RANGE] = opList[kind - 13];
        end else begin
            // Unknown opcode as the last kind
            word[`OPCODE_RANGE] = 6'h3f;
        end
        // Bias towards register 0 as destination
        if (randomBits(3) == 0) begin
            word[`RT_RANGE] = '0;
        end
        if (randomBits(3) == 0) begin
            word[`RD_RANGE] = '0;
        end
        // Half the branches compare a register with itself
        if ((word[`OPCODE_RANGE] == OP_BEQ || word[`OPCODE_RANGE] == OP_BNE)
            && randomBits(1) == 1) begin
            word[`RT_RANGE] = word[`RS_RANGE];
        end
        return word;
    endfunction

    // ********************
    // Reference decode
    // ********************

    function automatic decodeResult_t referenceDecode(input logic [31:0] word,
            input logic [31:0] pcVal, input logic [31:0] rsVal, input logic [31:0] rtVal);
        decodeResult_t r;
        logic [31:0] pcPlus4;
        logic [31:0] signImm;
        logic [31:0] zeroImm;
        logic [31:0] branchTarget;
        logic [31:0] jumpTarget;
        pcPlus4      = pcVal + 32'd4;
        signImm      = {{16{word[15]}}, word[15:0]};
        zeroImm      = {16'h0000, word[15:0]};
        branchTarget = pcPlus4 + {signImm[29:0], 2'b00};
        jumpTarget   = {pcPlus4[31:28], word[25:0], 2'b00};
        r          = '0;
        r.valid    = 1'b1;
        r.instr    = word;
        r.pc       = pcVal;
        r.memData  = rtVal;
        r.shamt    = word[`SHAMT_RANGE];
        // Unknown encodings keep these NOP defaults
        r.opA      = rsVal;
        r.opB      = zeroImm;
        r.writeReg = word[`RT_RANGE];
        r.aluOp    = ALU_NOP;
        case (word[`OPCODE_RANGE])
            OP_SPECIAL: begin
                r.opB      = rtVal;
                r.writeReg = word[`RD_RANGE];
                case (word[`FUNCT_RANGE])
                    F_SLL:  r.aluOp = ALU_SLL;
                    F_SRL:  r.aluOp = ALU_SRL;
                    F_SRA:  r.aluOp = ALU_SRA;
                    F_ADDU: r.aluOp = ALU_ADD;
                    F_SUBU: r.aluOp = ALU_SUB;
                    F_AND:  r.aluOp = ALU_AND;
                    F_OR:   r.aluOp = ALU_OR;
                    F_XOR:  r.aluOp = ALU_XOR;
                    F_NOR:  r.aluOp = ALU_NOR;
                    F_SLT:  r.aluOp = ALU_SLT;
                    F_JR: begin
                        r.altPc  = rsVal;
                        r.reqAlt = 1'b1;
                    end
                    F_JALR: begin
                        r.opA    = '0;
                        r.opB    = pcVal + 32'd8;
                        r.aluOp  = ALU_ADD;
                        r.altPc  = rsVal;
                        r.reqAlt = 1'b1;
                    end
                    F_SYSCALL: r.sys = 1'b1;
                    default: ;
                endcase
                r.regWrite = (r.aluOp != ALU_NOP);
            end
            OP_J: begin
                r.altPc  = jumpTarget;
                r.reqAlt = 1'b1;
            end
            OP_JAL: begin
                r.opA      = '0;
                r.opB      = pcVal + 32'd8;
                r.writeReg = 5'(`LINK_REG);
                r.regWrite = 1'b1;
                r.aluOp    = ALU_ADD;
                r.altPc    = jumpTarget;
                r.reqAlt   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                r.opB    = rtVal;
                r.aluOp  = ALU_SUB;
                r.altPc  = branchTarget;
                r.reqAlt = (rsVal == rtVal) == (word[`OPCODE_RANGE] == OP_BEQ);
            end
            OP_ADDIU: {r.opB, r.aluOp, r.regWrite} = {signImm, ALU_ADD, 1'b1};
            OP_SLTI:  {r.opB, r.aluOp, r.regWrite} = {signImm, ALU_SLT, 1'b1};
            OP_ANDI:  {r.aluOp, r.regWrite} = {ALU_AND, 1'b1};
            OP_ORI:   {r.aluOp, r.regWrite} = {ALU_OR, 1'b1};
            OP_XORI:  {r.aluOp, r.regWrite} = {ALU_XOR, 1'b1};
            OP_LUI:   {r.aluOp, r.regWrite} = {ALU_LUI, 1'b1};
            OP_LW:    {r.opB, r.aluOp, r.regWrite, r.memRead} = {signImm, ALU_ADD, 2'b11};
            OP_SW:    {r.opB, r.aluOp, r.memWrite} = {signImm, ALU_ADD, 1'b1};
            default: ;
        endcase
        // Register 0 never gets written
        r.regWrite = r.regWrite && (r.writeReg != '0);
        return r;
    endfunction

    // ********************
    // Drive and check
    // ********************

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERR %0t: %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    // One falling edge with an optional strobe and writeback
    task automatic driveCycle(input logic valid, input logic [31:0] word,
            input logic [31:0] pcVal, input logic we, input logic [4:0] wreg,
            input logic [31:0] wdata);
        @(negedge CLK);
        if (valid) begin
            expectedNext = referenceDecode(word, pcVal, shadow[word[`RS_RANGE]],
                                           shadow[word[`RT_RANGE]]);
        end else begin
            expectedNext = '0;
        end
        instrValid  = valid;
        instr       = word;
        pc          = pcVal;
        writeEnable = we;
        writeReg    = wreg;
        writeData   = wdata;
        // Write seen by the stage only from the next strobe on
        if (we && wreg != '0) begin
            shadow[wreg] = wdata;
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever begin
            #50 CLK = ~CLK;
        end
    end

    always @(posedge CLK) begin
        expectedNow <= expectedNext;
    end

    // Every cycle from the first falling edge on, reset cycles included
    initial begin
        forever begin
            @(negedge CLK);
            checkValue("outValid", 32'(outValid), 32'(expectedNow.valid));
            checkValue("instrOut", instrOut, expectedNow.instr);
            checkValue("pcOut", pcOut, expectedNow.pc);
            checkValue("operandA", operandA, expectedNow.opA);
            checkValue("operandB", operandB, expectedNow.opB);
            checkValue("writeRegOut", 32'(writeRegOut), 32'(expectedNow.writeReg));
            checkValue("regWriteOut", 32'(regWriteOut), 32'(expectedNow.regWrite));
            checkValue("memReadOut", 32'(memReadOut), 32'(expectedNow.memRead));
            checkValue("memWriteOut", 32'(memWriteOut), 32'(expectedNow.memWrite));
            checkValue("memWriteData", memWriteData, expectedNow.memData);
            checkValue("aluOpOut", 32'(aluOpOut), 32'(expectedNow.aluOp));
            checkValue("shiftAmount", 32'(shiftAmount), 32'(expectedNow.shamt));
            checkValue("altPc", altPc, expectedNow.altPc);
            checkValue("requestAltPc", 32'(requestAltPc), 32'(expectedNow.reqAlt));
            checkValue("sys", 32'(sys), 32'(expectedNow.sys));
        end
    end

    // Watchdog
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
        $display("=== FAIL ===");
        $finish;
    end

    // ********************
    // Stimulus
    // ********************

    initial begin
        logic [31:0] word;
        logic [31:0] pcVal;
        logic        we;
        RESET       = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        pc          = '0;
        writeEnable = 1'b0;
        writeReg    = '0;
        writeData   = '0;
        lfsrState   = 32'ha1b1_8647;
        for (int i = 0; i < `REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (resetCycles) @(negedge CLK);
        RESET = 1'b1;

        // Instruction bus toggles while no strobe is given
        for (int i = 0; i < idleCycles; i++) begin
            driveCycle(1'b0, randomBits(32), randomBits(32), 1'b0, '0, '0);
        end
        // Fill registers 1 to 31
        for (int r = 1; r < `REG_COUNT; r++) begin
            driveCycle(1'b0, '0, '0, 1'b1, 5'(r), randomBits(32));
        end

        // Bursts of strobes and gaps with writebacks mixed in
        for (int b = 0; b < numBursts; b++) begin
            for (int k = 0; k < burstLen + gapLen; k++) begin
                word  = randomInstr();
                pcVal = randomBits(30) << 2;
                we    = (randomBits(2) == 0);
                driveCycle(k < burstLen, word, pcVal, we, 5'(randomBits(5)), randomBits(32));
            end
        end

        repeat (tailCycles) driveCycle(1'b0, '0, '0, 1'b0, '0, '0);
        @(posedge CLK);
        $display("Decode stage run: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
